/* speaker.f */
+incdir+.
speaker_pkg.sv
button_conditioner.sv
sound_setting.sv
tone_generator.sv
i2s_serializer.sv
volume_display.sv
speaker.sv
speaker_assert.sv
speaker_clk_gen.sv
speaker_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= speaker_tb
FILELIST  ?= speaker.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* speaker_tb.sv */
`timescale 1ns/1ps
`include "speaker_params.svh"

module speaker_tb
	import speaker_pkg::*;
();
	localparam int NSTEPS      = 40;
	localparam int IDLE        = 500;
	localparam int SETTLE      = 230;
	localparam int DISP_SETTLE = 280;
	localparam int FRAME_CYC   = 64 * `SPK_BCK_HALF;

	localparam int T_RESET   = 0;
	localparam int T_VOLUME  = 1;
	localparam int T_AMP     = 2;
	localparam int T_FREQ    = 3;
	localparam int T_SILENCE = 4;
	localparam int NTESTS    = 5;

	logic       clk;
	logic       rst;
	logic [2:0] note_btn;
	logic [1:0] vol_btn;
	logic       bck;
	logic       ws;
	logic       sdata;
	logic [6:0] seg;
	logic [1:0] an;

	int seed;
	int cycle = 0;
	int limit = 0;
	int hold [NSTEPS];
	int checks [NTESTS];
	int errors [NTESTS];

	// Model state
	int   exp_note;
	int   exp_level;
	int   last_change;
	int   last_level_chg;
	int   run_ref;
	logic in_reset_phase;

	// Decoder state
	int          disp_tens;
	int          disp_units;
	logic        bck_q;
	logic        ws_q;
	logic [31:0] fbits;
	int          nbits;
	int          run_note;
	int          run_frames;
	int          run_changes;
	int          run_sign;

	speaker_clk_gen clkgen (.clk(clk), .rst(rst));

	speaker uut (
		.clk(clk), .rst(rst),
		.note_btn(note_btn), .vol_btn(vol_btn),
		.bck(bck), .ws(ws), .sdata(sdata),
		.seg(seg), .an(an)
	);

	function automatic string test_name(input int t);
		case (t)
			T_RESET:  return "after_reset";
			T_VOLUME: return "volume_steps";
			T_AMP:    return "amplitude";
			T_FREQ:   return "frequency";
			default:  return "silence";
		endcase
	endfunction

	function automatic int note_half_period(input int code);
		case (code)
			1:       return `SPK_NOTE_1;
			2:       return `SPK_NOTE_2;
			3:       return `SPK_NOTE_3;
			4:       return `SPK_NOTE_4;
			5:       return `SPK_NOTE_5;
			6:       return `SPK_NOTE_6;
			7:       return `SPK_NOTE_7;
			default: return 0;
		endcase
	endfunction

	// Active low gfedcba back to a digit, 15 if unreadable
	function automatic int seg_to_digit(input logic [6:0] s);
		case (s)
			7'b1000000: return 0;
			7'b1111001: return 1;
			7'b0100100: return 2;
			7'b0110000: return 3;
			7'b0011001: return 4;
			7'b0010010: return 5;
			7'b0000010: return 6;
			7'b1111000: return 7;
			7'b0000000: return 8;
			7'b0010000: return 9;
			default:    return 15;
		endcase
	endfunction

	task automatic check(input int t, input bit ok, input int exp_v, input int act_v);
		checks[t]++;
		assert (ok) else begin
			$display("[FAIL] %s expected %0d actual %0d", test_name(t), exp_v, act_v);
			errors[t]++;
		end
	endtask

	task automatic check_display(input int t);
		check(t, disp_tens == exp_level / 10, exp_level / 10, disp_tens);
		check(t, disp_units == exp_level % 10, exp_level % 10, disp_units);
	endtask

	task automatic report(input int t);
		if (checks[t] == 0) begin
			$display("Test %s ran no checks", test_name(t));
			errors[t]++;
		end
		$display("Test %-12s %0d checks, %0d errors", test_name(t), checks[t], errors[t]);
	endtask

	// Sign changes over the run against the note's half period
	task automatic end_run();
		int hp;
		int diff;
		hp = note_half_period(run_note);
		if (run_frames >= 2 && hp > 0) begin
			diff = run_changes * hp - (run_frames - 1) * FRAME_CYC;
			if (diff < 0) begin
				diff = -diff;
			end
			check(T_FREQ, diff <= hp, ((run_frames - 1) * FRAME_CYC) / hp, run_changes);
		end
		run_frames  = 0;
		run_changes = 0;
	endtask

	task automatic check_frame(input sample_t left, input sample_t right);
		int mag;
		int sgn;
		if (cycle - last_change >= SETTLE) begin
			if (exp_note == 0) begin
				check(in_reset_phase ? T_RESET : T_SILENCE, left == 0 && right == 0, 0,
					(left != 0) ? left : right);
			end else begin
				mag = (left < 0) ? -left : left;
				check(T_AMP, left == right, left, right);
				check(T_AMP, mag == exp_level * `SPK_VOL_STEP, exp_level * `SPK_VOL_STEP, mag);
			end
		end
		if (exp_note != 0 && exp_level != 0 && cycle - run_ref >= SETTLE) begin
			sgn = (left > 0) ? 1 : 0;
			if (run_frames > 0 && sgn != run_sign) begin
				run_changes++;
			end
			run_sign = sgn;
			run_frames++;
		end
	endtask

	task automatic press_volume(input bit up, input int len);
		logic [1:0] mask;
		int         next_level;
		int         width;
		mask = up ? 2'b01 : 2'b10;
		// Bounce under four sample ticks, then a low sample
		if ($random(seed) & 1) begin
			width = 8 + ($unsigned($random(seed)) % 33);
			vol_btn <= mask;
			repeat (width) @(posedge clk);
			vol_btn <= 2'b00;
			repeat (20) @(posedge clk);
		end
		vol_btn <= mask;
		if (up) begin
			next_level = (exp_level < `SPK_VOL_MAX) ? exp_level + 1 : exp_level;
		end else begin
			next_level = (exp_level > 0) ? exp_level - 1 : 0;
		end
		if (next_level != exp_level) begin
			if (exp_level == 0) begin
				run_ref <= cycle;
			end
			exp_level      <= next_level;
			last_change    <= cycle;
			last_level_chg <= cycle;
		end
		repeat (len) @(posedge clk);
		vol_btn <= 2'b00;
		repeat (90) @(posedge clk);
	endtask

	////////////////////
	// Cycle count and timeout
	////////////////////

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (limit > 0 && cycle >= limit) begin
			$display("Timeout after %0d cycles, stimulus did not complete", cycle);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////
	// Decoders
	////////////////////

	always @(posedge clk) begin
		if (rst) begin
			bck_q       = 1'b0;
			ws_q        = 1'b0;
			fbits       = '0;
			nbits       = 0;
			run_note    = 0;
			run_frames  = 0;
			run_changes = 0;
			run_sign    = 0;
			disp_tens  <= 15;
			disp_units <= 15;
		end else begin
			// Tone run ends on a new note or at level zero
			if (exp_note != run_note || exp_level == 0) begin
				end_run();
				run_note = exp_note;
			end
			if (an == 2'b01) begin
				disp_tens <= seg_to_digit(seg);
			end
			if (an == 2'b10) begin
				disp_units <= seg_to_digit(seg);
			end
			// Sample sdata on rising bck, a falling ws opens a frame
			if (bck && !bck_q) begin
				if (!ws && ws_q) begin
					if (nbits == 32) begin
						check_frame(sample_t'(fbits[31:16]), sample_t'(fbits[15:0]));
					end
					fbits = {31'b0, sdata};
					nbits = 1;
				end else begin
					fbits = {fbits[30:0], sdata};
					nbits = nbits + 1;
				end
				ws_q = ws;
			end
			bck_q = bck;
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial begin
		int sum;
		int kind;
		int code;
		int total_c;
		int total_e;
		note_btn       <= 3'b000;
		vol_btn        <= 2'b00;
		exp_note       <= 0;
		exp_level      <= `SPK_VOL_RESET;
		last_change    <= 0;
		last_level_chg <= 0;
		run_ref        <= 0;
		in_reset_phase <= 1'b1;
		seed = 5;
		sum  = 2 * IDLE;
		for (int i = 0; i < NSTEPS; i++) begin
			hold[i] = 120 + ($unsigned($random(seed)) % 281);
			sum += hold[i];
		end
		limit = 2 * sum + 2000;

		wait (rst == 1'b0);
		@(posedge clk);
		last_change    <= cycle;
		last_level_chg <= cycle;
		run_ref        <= cycle;
		repeat (IDLE) @(posedge clk);
		check_display(T_RESET);
		in_reset_phase <= 1'b0;
		report(T_RESET);

		// One note step for every two volume presses on average
		for (int i = 0; i < NSTEPS; i++) begin
			kind = $unsigned($random(seed)) % 3;
			if (kind == 0) begin
				code = $unsigned($random(seed)) % 8;
				note_btn <= code[2:0];
				if (code != exp_note) begin
					exp_note    <= code;
					last_change <= cycle;
					run_ref     <= cycle;
				end
				repeat (hold[i]) @(posedge clk);
			end else begin
				press_volume(kind == 1, hold[i]);
			end
			if (cycle - last_level_chg >= DISP_SETTLE) begin
				check_display(T_VOLUME);
			end
		end

		// Closing silence
		note_btn <= 3'b000;
		if (exp_note != 0) begin
			exp_note    <= 0;
			last_change <= cycle;
			run_ref     <= cycle;
		end
		repeat (IDLE) @(posedge clk);
		check_display(T_VOLUME);

		total_c = 0;
		total_e = 0;
		for (int t = T_VOLUME; t < NTESTS; t++) begin
			report(t);
		end
		for (int t = 0; t < NTESTS; t++) begin
			total_c += checks[t];
			total_e += errors[t];
		end
		$display("Checks %0d, errors %0d", total_c, total_e);
		if (total_e == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* speaker_clk_gen.sv */
`timescale 1ns/1ps

module speaker_clk_gen (
	output logic clk,
	output logic rst
);
	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rst <= 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* speaker_assert.sv */
`timescale 1ns/1ps

module speaker_assert (
	input logic       clk,
	input logic       rst,
	input logic       bck,
	input logic       ws,
	input logic       sdata,
	input logic [1:0] an
);
	// Word select moves only together with a falling bit clock
	ws_on_bck_fall: assert property (
		@(posedge clk) disable iff (rst) $changed(ws) |-> $fell(bck)
	) else $error("ws changed without a falling bck edge");

	// Data must hold while the DAC samples it
	sdata_hold: assert property (
		@(posedge clk) disable iff (rst) bck |-> $stable(sdata)
	) else $error("sdata changed while bck was high");

	one_digit_on: assert property (
		@(posedge clk) disable iff (rst) $onehot0(~an)
	) else $error("both digit enables are active");

endmodule

// Serializer pins and display enables seen together at the top level
bind speaker speaker_assert top_checks (
	.clk(clk), .rst(rst), .bck(bck), .ws(ws), .sdata(sdata), .an(an)
);

/* speaker.sv */
`timescale 1ns/1ps

module speaker
	import speaker_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic [2:0] note_btn,
	input  logic [1:0] vol_btn,
	output logic       bck,
	output logic       ws,
	output logic       sdata,
	output logic [6:0] seg,
	output logic [1:0] an
);
	note_code_t   note_code;
	logic         vol_up;
	logic         vol_down;
	half_period_t half_period;
	logic         note_on;
	vol_level_t   vol_level;
	sample_t      sample_left;
	sample_t      sample_right;

	// Buttons
	button_conditioner u_btn (
		.clk(clk), .rst(rst),
		.note_btn(note_btn), .vol_btn(vol_btn),
		.note_code(note_code), .vol_up(vol_up), .vol_down(vol_down)
	);

	// Note and volume
	sound_setting u_set (
		.clk(clk), .rst(rst),
		.note_code(note_code), .vol_up(vol_up), .vol_down(vol_down),
		.half_period(half_period), .note_on(note_on), .vol_level(vol_level)
	);

	tone_generator u_tone (
		.clk(clk), .rst(rst),
		.half_period(half_period), .note_on(note_on), .vol_level(vol_level),
		.sample_left(sample_left), .sample_right(sample_right)
	);

	// DAC link
	i2s_serializer u_i2s (
		.clk(clk), .rst(rst),
		.sample_left(sample_left), .sample_right(sample_right),
		.bck(bck), .ws(ws), .sdata(sdata)
	);

	volume_display u_disp (
		.clk(clk), .rst(rst),
		.vol_level(vol_level), .seg(seg), .an(an)
	);

endmodule

/* volume_display.sv */
`timescale 1ns/1ps
`include "speaker_params.svh"

module volume_display
	import speaker_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  vol_level_t vol_level,
	output seg_t       seg,
	output logic [1:0] an
);
	localparam int SCAN_W = $clog2(`SPK_SCAN_DIV);

	logic [SCAN_W-1:0] scan_cnt;
	logic              scan_on;
	digit_sel_t        digit_sel;
	bcd_t              tens;
	bcd_t              units;
	bcd_t              digit;

	// Segment order gfedcba, active low
	function automatic seg_t bcd_to_seg(input bcd_t d);
		case (d)
			4'd0:    return 7'b1000000;
			4'd1:    return 7'b1111001;
			4'd2:    return 7'b0100100;
			4'd3:    return 7'b0110000;
			4'd4:    return 7'b0011001;
			4'd5:    return 7'b0010010;
			4'd6:    return 7'b0000010;
			4'd7:    return 7'b1111000;
			4'd8:    return 7'b0000000;
			4'd9:    return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	// Level never exceeds 15, one compare is enough
	assign tens  = (vol_level >= 4'd10) ? bcd_t'(1) : bcd_t'(0);
	assign units = (vol_level >= 4'd10) ? bcd_t'(vol_level - 4'd10) : bcd_t'(vol_level);
	assign digit = (digit_sel == DIGIT_TENS) ? tens : units;

	////////////////////
	// Digit scan
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			scan_cnt  <= '0;
			scan_on   <= 1'b0;
			digit_sel <= DIGIT_UNITS;
		end else if (scan_cnt == SCAN_W'(`SPK_SCAN_DIV - 1)) begin
			scan_cnt  <= '0;
			scan_on   <= 1'b1;
			digit_sel <= (digit_sel == DIGIT_TENS) ? DIGIT_UNITS : DIGIT_TENS;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// Dark until the first scan step, tens on an[1]
	assign an  = !scan_on ? 2'b11 : ((digit_sel == DIGIT_TENS) ? 2'b01 : 2'b10);
	assign seg = scan_on ? bcd_to_seg(digit) : 7'b1111111;

endmodule

/* i2s_serializer.sv */
`timescale 1ns/1ps
`include "speaker_params.svh"

module i2s_serializer
	import speaker_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  sample_t sample_left,
	input  sample_t sample_right,
	output logic    bck,
	output logic    ws,
	output logic    sdata
);
	localparam int DIV_W = ($clog2(`SPK_BCK_HALF) > 0) ? $clog2(`SPK_BCK_HALF) : 1;

	logic [DIV_W-1:0] div_cnt;
	logic             bck_edge;
	logic [4:0]       bit_cnt;
	logic [4:0]       bit_next;
	logic [31:0]      shift;

	assign bck_edge = (div_cnt == DIV_W'(`SPK_BCK_HALF - 1));
	assign bit_next = bit_cnt + 1'b1;

	////////////////////
	// Bit clock and framing
	////////////////////

	// Bit counter starts at 31 so the first falling edge opens a frame
	always_ff @(posedge clk) begin
		if (rst) begin
			div_cnt <= '0;
			bck     <= 1'b0;
			bit_cnt <= 5'd31;
			ws      <= 1'b0;
			shift   <= '0;
		end else if (bck_edge) begin
			div_cnt <= '0;
			bck     <= ~bck;
			if (bck) begin
				// Falling edge of bck
				bit_cnt <= bit_next;
				ws      <= bit_next[4];
				if (bit_cnt == 5'd31) begin
					shift <= {sample_left, sample_right};
				end else begin
					shift <= {shift[30:0], 1'b0};
				end
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// MSB first, left word then right word
	assign sdata = shift[31];

endmodule

/* tone_generator.sv */
`timescale 1ns/1ps
`include "speaker_params.svh"

module tone_generator
	import speaker_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  half_period_t half_period,
	input  logic         note_on,
	input  vol_level_t   vol_level,
	output sample_t      sample_left,
	output sample_t      sample_right
);
	half_period_t cyc_cnt;
	half_period_t hp_prev;
	logic         phase;
	sample_t      amp;
	sample_t      sample;

	assign amp = sample_t'(vol_level) * sample_t'(`SPK_VOL_STEP);

	always_ff @(posedge clk) begin
		if (rst || !note_on) begin
			cyc_cnt <= '0;
			phase   <= 1'b0;
		end else if (half_period != hp_prev) begin
			// New note, start counting again
			cyc_cnt <= '0;
		end else if (cyc_cnt == half_period - 1'b1) begin
			cyc_cnt <= '0;
			phase   <= ~phase;
		end else begin
			cyc_cnt <= cyc_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			hp_prev <= '0;
			sample  <= '0;
		end else begin
			hp_prev <= half_period;
			if (!note_on) begin
				sample <= '0;
			end else begin
				sample <= phase ? amp : -amp;
			end
		end
	end

	// Mono tone on both channels
	assign sample_left  = sample;
	assign sample_right = sample;

endmodule

/* sound_setting.sv */
`timescale 1ns/1ps
`include "speaker_params.svh"

module sound_setting
	import speaker_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  note_code_t   note_code,
	input  logic         vol_up,
	input  logic         vol_down,
	output half_period_t half_period,
	output logic         note_on,
	output vol_level_t   vol_level
);
	localparam vol_level_t VOL_MAX   = vol_level_t'(`SPK_VOL_MAX);
	localparam vol_level_t VOL_RESET = vol_level_t'(`SPK_VOL_RESET);

	// Note table lookup
	always_comb begin
		case (note_code)
			3'd1:    half_period = half_period_t'(`SPK_NOTE_1);
			3'd2:    half_period = half_period_t'(`SPK_NOTE_2);
			3'd3:    half_period = half_period_t'(`SPK_NOTE_3);
			3'd4:    half_period = half_period_t'(`SPK_NOTE_4);
			3'd5:    half_period = half_period_t'(`SPK_NOTE_5);
			3'd6:    half_period = half_period_t'(`SPK_NOTE_6);
			3'd7:    half_period = half_period_t'(`SPK_NOTE_7);
			default: half_period = '0;
		endcase
	end

	assign note_on = (note_code != '0);

	// Saturating level, up has priority
	always_ff @(posedge clk) begin
		if (rst) begin
			vol_level <= VOL_RESET;
		end else if (vol_up) begin
			if (vol_level != VOL_MAX) begin
				vol_level <= vol_level + 1'b1;
			end
		end else if (vol_down) begin
			if (vol_level != '0) begin
				vol_level <= vol_level - 1'b1;
			end
		end
	end

endmodule

/* button_conditioner.sv */
`timescale 1ns/1ps
`include "speaker_params.svh"

module button_conditioner
	import speaker_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic [2:0] note_btn,
	input  logic [1:0] vol_btn,
	output note_code_t note_code,
	output logic       vol_up,
	output logic       vol_down
);
	localparam int PRE_W = $clog2(`SPK_SAMPLE_DIV);
	localparam int CNT_W = $clog2(`SPK_DEBOUNCE_LEN);
	localparam int NBTN  = 5;

	logic [PRE_W-1:0] pre_cnt;
	logic             tick;
	logic [NBTN-1:0]  btn_raw;
	logic [NBTN-1:0]  btn_deb;
	logic [CNT_W-1:0] diff_cnt [NBTN];
	logic [1:0]       vol_dly;

	// Bits 2:0 notes, bit 3 volume up, bit 4 volume down
	assign btn_raw = {vol_btn, note_btn};
	assign tick    = (pre_cnt == PRE_W'(`SPK_SAMPLE_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst || tick) begin
			pre_cnt <= '0;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	// Level flips after enough consecutive samples that disagree with it
	always_ff @(posedge clk) begin
		if (rst) begin
			btn_deb <= '0;
			for (int i = 0; i < NBTN; i++) begin
				diff_cnt[i] <= '0;
			end
		end else if (tick) begin
			for (int i = 0; i < NBTN; i++) begin
				if (btn_raw[i] == btn_deb[i]) begin
					diff_cnt[i] <= '0;
				end else if (diff_cnt[i] == CNT_W'(`SPK_DEBOUNCE_LEN - 1)) begin
					btn_deb[i]  <= btn_raw[i];
					diff_cnt[i] <= '0;
				end else begin
					diff_cnt[i] <= diff_cnt[i] + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vol_dly <= '0;
		end else begin
			vol_dly <= btn_deb[4:3];
		end
	end

	// One cycle pulse on each debounced press
	assign vol_up    = btn_deb[3] & ~vol_dly[0];
	assign vol_down  = btn_deb[4] & ~vol_dly[1];
	assign note_code = note_code_t'(btn_deb[2:0]);

endmodule

/* speaker_pkg.sv */
package speaker_pkg;

	////////////////////
	// Button side
	////////////////////

	// Binary note selection, 0 is silence
	typedef logic [2:0] note_code_t;

	////////////////////
	// Audio path
	////////////////////

	// Half period of a tone in clk cycles
	typedef logic [19:0] half_period_t;

	// Volume level 0 to 15
	typedef logic [3:0] vol_level_t;

	// Two's complement sample sent to the DAC
	typedef logic signed [15:0] sample_t;

	////////////////////
	// Display side
	////////////////////

	typedef logic [3:0] bcd_t;

	// Active low, bit 0 is segment a and bit 6 is segment g
	typedef logic [6:0] seg_t;

	// Which digit the scan is driving
	typedef enum logic {DIGIT_TENS, DIGIT_UNITS} digit_sel_t;

endpackage

/* speaker_params.svh */
`ifndef SPEAKER_PARAMS_SVH
`define SPEAKER_PARAMS_SVH

// Debounce sampling
`define SPK_SAMPLE_DIV   16
`define SPK_DEBOUNCE_LEN 4

// Volume range and sample scaling
`define SPK_VOL_MAX   15
`define SPK_VOL_RESET 8
`define SPK_VOL_STEP  2048

// I2S bit clock, clk cycles per half period
`define SPK_BCK_HALF 2

// Display scan, clk cycles per digit
`define SPK_SCAN_DIV 32

// Note table, half periods in clk cycles
`define SPK_NOTE_1 400
`define SPK_NOTE_2 356
`define SPK_NOTE_3 317
`define SPK_NOTE_4 300
`define SPK_NOTE_5 267
`define SPK_NOTE_6 238
`define SPK_NOTE_7 212

`endif
